/* verilog/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and storage sizes
`define WORD_WIDTH      16
`define REG_ADDR_WIDTH  3
`define NUM_REGS        8
`define DMEM_ADDR_WIDTH 8
`define DMEM_DEPTH      256

// opcode field, inst[15:12]
`define OPCODE_WIDTH    4
`define OP_NOP          4'h0
`define OP_ADD          4'h1
`define OP_SUB          4'h2
`define OP_AND          4'h3
`define OP_OR           4'h4
`define OP_XOR          4'h5
`define OP_SLT          4'h6
`define OP_LI           4'h7
`define OP_ADDI         4'h8
`define OP_LW           4'h9
`define OP_SW           4'ha
`define OP_BEQZ         4'hb
`define OP_BNEZ         4'hc

`endif

/* verilog/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [2:0] alu_op_t;

	// alu functions
	localparam alu_op_t ALU_ADD    = 3'd0;
	localparam alu_op_t ALU_SUB    = 3'd1;
	localparam alu_op_t ALU_AND    = 3'd2;
	localparam alu_op_t ALU_OR     = 3'd3;
	localparam alu_op_t ALU_XOR    = 3'd4;
	localparam alu_op_t ALU_SLT    = 3'd5;
	localparam alu_op_t ALU_PASS_B = 3'd6;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		alu_op_t   alu_op;
		word_t     op_a;
		word_t     op_b;
		word_t     store_data;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		reg_addr_t dest;
	} id_exe_t;

	// one register write, used for bypass and retire
	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     value;
	} retire_t;

	typedef enum logic [1:0] {IDLE, BUSY, DONE} mem_state_t;

endpackage

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  retire_t   exe_fwd,
	input  retire_t   wb
);

	word_t regs [`NUM_REGS];

	// newest value wins: exe result, then the wb write, then the array
	function automatic word_t bypass(reg_addr_t ra, retire_t exe_w, retire_t wb_w, word_t arr);
		if (exe_w.en && exe_w.addr == ra) begin
			return exe_w.value;
		end
		if (wb_w.en && wb_w.addr == ra) begin
			return wb_w.value;
		end
		return arr;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.addr] <= wb.value;
		end
	end

	assign rdata1 = bypass(raddr1, exe_fwd, wb, regs[raddr1]);
	assign rdata2 = bypass(raddr2, exe_fwd, wb, regs[raddr2]);

	assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> !$isunknown(wb.addr));

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decoder import cpu_pkg::*; (
	input  word_t     inst,
	output reg_addr_t raddr1,
	output reg_addr_t raddr2,
	output alu_op_t   alu_op,
	output word_t     imm,
	output logic      use_imm,
	output logic      mem_read,
	output logic      mem_write,
	output logic      reg_write,
	output logic      branch,
	output logic      branch_on_zero,
	output reg_addr_t dest
);

	logic [`OPCODE_WIDTH-1:0] opcode;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t imm6_sext;
	word_t imm8_zext;
	word_t imm9_sext;

	assign opcode = inst[15:12];
	assign rd = inst[11:9];
	assign rs = inst[8:6];
	assign rt = inst[5:3];

	assign imm6_sext = {{(`WORD_WIDTH-6){inst[5]}}, inst[5:0]};
	assign imm8_zext = {{(`WORD_WIDTH-8){1'b0}}, inst[7:0]};
	assign imm9_sext = {{(`WORD_WIDTH-9){inst[8]}}, inst[8:0]};

	always_comb begin
		// nop unless the opcode says otherwise
		raddr1 = rs;
		raddr2 = rt;
		alu_op = ALU_ADD;
		imm = '0;
		use_imm = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		branch = 1'b0;
		branch_on_zero = 1'b0;
		dest = rd;
		case (opcode)
			`OP_ADD: begin
				reg_write = 1'b1;
			end
			`OP_SUB: begin
				alu_op = ALU_SUB;
				reg_write = 1'b1;
			end
			`OP_AND: begin
				alu_op = ALU_AND;
				reg_write = 1'b1;
			end
			`OP_OR: begin
				alu_op = ALU_OR;
				reg_write = 1'b1;
			end
			`OP_XOR: begin
				alu_op = ALU_XOR;
				reg_write = 1'b1;
			end
			`OP_SLT: begin
				alu_op = ALU_SLT;
				reg_write = 1'b1;
			end
			`OP_LI: begin
				alu_op = ALU_PASS_B;
				imm = imm8_zext;
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			`OP_ADDI, `OP_LW: begin
				imm = imm6_sext;
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = (opcode == `OP_LW);
			end
			`OP_SW: begin
				// rd goes out on port 2 as store data
				raddr2 = rd;
				imm = imm6_sext;
				use_imm = 1'b1;
				mem_write = 1'b1;
			end
			`OP_BEQZ, `OP_BNEZ: begin
				raddr1 = rd;
				imm = imm9_sext;
				branch = 1'b1;
				branch_on_zero = (opcode == `OP_BEQZ);
			end
			default: begin
			end
		endcase
	end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  alu_op_t alu_op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result
);

	always_comb begin
		case (alu_op)
			ALU_ADD: begin
				// also the lw and sw address
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_SLT: begin
				// signed compare, zero extended to a word
				result = word_t'($signed(a) < $signed(b));
			end
			ALU_PASS_B: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* verilog/mem_ctrl.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_ctrl import cpu_pkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        mem_read,
	input  logic                        mem_write,
	input  word_t                       addr,
	input  word_t                       wdata,
	output word_t                       rdata,
	output logic                        done,
	output logic                        cyc,
	output logic                        stb,
	output logic                        we,
	output logic [`DMEM_ADDR_WIDTH-1:0] adr,
	output word_t                       dat_w,
	input  word_t                       dat_r,
	input  logic                        ack
);

	mem_state_t state;
	logic req;
	logic [`DMEM_ADDR_WIDTH-1:0] adr_q;
	logic we_q;
	word_t dat_w_q;

	assign req = mem_read || mem_write;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: state <= req ? BUSY : IDLE;
				BUSY: state <= ack ? DONE : BUSY;
				default: state <= IDLE;
			endcase
		end
	end

	// request captured as it goes out, read data on ack
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			adr_q <= addr[`DMEM_ADDR_WIDTH-1:0];
			we_q <= mem_write;
			dat_w_q <= wdata;
		end
		if (state == BUSY && ack) begin
			rdata <= dat_r;
		end
	end

	// strobe goes out in idle so ack lands while busy
	assign cyc = (state == IDLE && req) || state == BUSY;
	assign stb = cyc;
	assign we = (state == IDLE) ? mem_write : we_q;
	assign adr = (state == IDLE) ? addr[`DMEM_ADDR_WIDTH-1:0] : adr_q;
	assign dat_w = (state == IDLE) ? wdata : dat_w_q;
	assign done = (state == DONE);

	assert property (@(posedge clk) disable iff (!rst_n) ack |-> cyc);
	assert property (@(posedge clk) disable iff (!rst_n)
		stb && !ack |=> stb && $stable(adr) && $stable(we) && $stable(dat_w));

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module data_ram import cpu_pkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cyc,
	input  logic                        stb,
	input  logic                        we,
	input  logic [`DMEM_ADDR_WIDTH-1:0] adr,
	input  word_t                       dat_w,
	output word_t                       dat_r,
	output logic                        ack
);

	word_t mem [`DMEM_DEPTH];
	logic access;

	initial begin
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// new request, not yet acknowledged
	assign access = cyc && stb && !ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			dat_r <= mem[adr];
		end
		if (cyc && stb && we && ack) begin
			mem[adr] <= dat_w;
		end
	end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	output word_t   inst_addr,
	input  word_t   inst,
	output retire_t retire
);

	word_t pc;
	if_id_t if_id;
	id_exe_t id_exe;
	retire_t exe_fwd;
	logic hold;
	logic exe_mem_op;

	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t rdata1;
	word_t rdata2;
	alu_op_t dec_alu_op;
	word_t dec_imm;
	logic dec_use_imm;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_reg_write;
	logic dec_branch;
	logic dec_branch_on_zero;
	reg_addr_t dec_dest;

	logic branch_taken;
	word_t branch_target;
	word_t alu_result;
	word_t mem_rdata;
	logic mem_done;

	logic bus_cyc;
	logic bus_stb;
	logic bus_we;
	logic bus_ack;
	logic [`DMEM_ADDR_WIDTH-1:0] bus_adr;
	word_t bus_dat_w;
	word_t bus_dat_r;

	// IF
	assign inst_addr = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (!hold) begin
			pc <= branch_taken ? branch_target : pc + 16'd1;
			if_id.valid <= 1'b1;
			if_id.pc <= pc;
			if_id.inst <= inst;
		end
	end

	// ID, branch resolves here with one delay slot
	decoder u_decoder (
		.inst(if_id.inst),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.alu_op(dec_alu_op),
		.imm(dec_imm),
		.use_imm(dec_use_imm),
		.mem_read(dec_mem_read),
		.mem_write(dec_mem_write),
		.reg_write(dec_reg_write),
		.branch(dec_branch),
		.branch_on_zero(dec_branch_on_zero),
		.dest(dec_dest)
	);

	reg_file u_reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.exe_fwd(exe_fwd),
		.wb(retire)
	);

	assign branch_target = if_id.pc + 16'd1 + dec_imm;
	assign branch_taken = if_id.valid && dec_branch &&
		((rdata1 == '0) == dec_branch_on_zero);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_exe.valid <= 1'b0;
		end else if (!hold) begin
			id_exe.valid <= if_id.valid;
			id_exe.alu_op <= dec_alu_op;
			id_exe.op_a <= rdata1;
			id_exe.op_b <= dec_use_imm ? dec_imm : rdata2;
			id_exe.store_data <= rdata2;
			id_exe.mem_read <= dec_mem_read;
			id_exe.mem_write <= dec_mem_write;
			id_exe.reg_write <= dec_reg_write;
			id_exe.dest <= dec_dest;
		end
	end

	// EXE
	alu u_alu (
		.alu_op(id_exe.alu_op),
		.a(id_exe.op_a),
		.b(id_exe.op_b),
		.result(alu_result)
	);

	mem_ctrl u_mem_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(id_exe.valid && id_exe.mem_read),
		.mem_write(id_exe.valid && id_exe.mem_write),
		.addr(alu_result),
		.wdata(id_exe.store_data),
		.rdata(mem_rdata),
		.done(mem_done),
		.cyc(bus_cyc),
		.stb(bus_stb),
		.we(bus_we),
		.adr(bus_adr),
		.dat_w(bus_dat_w),
		.dat_r(bus_dat_r),
		.ack(bus_ack)
	);

	data_ram u_data_ram (
		.clk(clk),
		.rst_n(rst_n),
		.cyc(bus_cyc),
		.stb(bus_stb),
		.we(bus_we),
		.adr(bus_adr),
		.dat_w(bus_dat_w),
		.dat_r(bus_dat_r),
		.ack(bus_ack)
	);

	// stall while the data access is in flight
	assign exe_mem_op = id_exe.valid && (id_exe.mem_read || id_exe.mem_write);
	assign hold = exe_mem_op && !mem_done;

	assign exe_fwd.en = id_exe.valid && id_exe.reg_write && !hold;
	assign exe_fwd.addr = id_exe.dest;
	assign exe_fwd.value = id_exe.mem_read ? mem_rdata : alu_result;

	// WB, a bubble goes in while held
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire.en <= 1'b0;
		end else begin
			retire <= exe_fwd;
		end
	end

	// memory op in EXE holds for two cycles, then releases
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(hold) |-> exe_mem_op ##1 hold ##1 !hold);

endmodule

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int PROG_LEN = 64;
	localparam int WAIT_CYCLES = 2000;
	localparam int QUIET_CYCLES = 200;
	localparam word_t NOP_WORD = {`OP_NOP, 12'h000};

	logic clk;
	logic rst_n;
	word_t inst_addr;
	word_t inst;
	retire_t retire;

	word_t prog [PROG_LEN];
	// mirrors the data RAM, which keeps its contents across resets
	word_t model_mem [`DMEM_DEPTH];
	retire_t expected [$];

	int test_errors;
	int tests_passed;
	int tests_failed;

	cpu_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.inst_addr(inst_addr),
		.inst(inst),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10;
			clk = ~clk;
		end
	end

	// past the program everything reads as nop
	function automatic word_t fetch(word_t addr);
		if (int'(addr) < PROG_LEN) begin
			return prog[addr[5:0]];
		end
		return NOP_WORD;
	endfunction

	// instruction rom answering the fetch pc
	initial begin
		inst = NOP_WORD;
		forever begin
			@(posedge clk);
			#2;
			inst = fetch(inst_addr);
		end
	end

	// small register span gives lots of back-to-back dependencies
	function automatic word_t random_inst(logic allow_mem, logic allow_branch, int reg_span);
		int pick;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		rd = reg_addr_t'($urandom % reg_span);
		rs = reg_addr_t'($urandom % reg_span);
		rt = reg_addr_t'($urandom % reg_span);
		pick = int'($urandom % 16);
		if (!allow_mem && pick >= 10 && pick <= 12) begin
			pick = pick - 10;
		end
		if (!allow_branch && (pick == 13 || pick == 14)) begin
			pick = pick - 10;
		end
		case (pick)
			0, 1, 2, 3, 4, 5: return {4'(pick + 1), rd, rs, rt, 3'b000};
			6, 7: return {`OP_LI, rd, 1'b0, 8'($urandom)};
			8, 9: return {`OP_ADDI, rd, rs, 6'($urandom)};
			10, 11: return {`OP_LW, rd, rs, 6'($urandom)};
			12: return {`OP_SW, rd, rs, 6'($urandom)};
			13: return {`OP_BEQZ, rd, 9'(1 + $urandom % 7)};
			14: return {`OP_BNEZ, rd, 9'(1 + $urandom % 7)};
			default: return NOP_WORD;
		endcase
	endfunction

	// fills prog from start on, never a branch in a delay slot
	task automatic fill_random(int start, logic allow_mem, logic allow_branch, int reg_span);
		logic after_branch;
		after_branch = 1'b0;
		for (int i = start; i < PROG_LEN; i++) begin
			prog[i] = random_inst(allow_mem, allow_branch && !after_branch, reg_span);
			after_branch = (prog[i][15:12] == `OP_BEQZ) || (prog[i][15:12] == `OP_BNEZ);
		end
	endtask

	// sequential ISA model with one delay slot, fills the expected write list
	task automatic run_model();
		word_t regs [`NUM_REGS];
		int pc;
		int next_pc;
		int target;
		logic pending;
		logic writes;
		logic [3:0] op;
		reg_addr_t rd;
		word_t iw;
		word_t a;
		word_t b;
		word_t res;
		word_t addr;
		retire_t w;
		expected.delete();
		for (int i = 0; i < `NUM_REGS; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		target = 0;
		pending = 1'b0;
		while (pc < PROG_LEN || pending) begin
			iw = fetch(16'(pc));
			op = iw[15:12];
			rd = iw[11:9];
			a = regs[iw[8:6]];
			b = regs[iw[5:3]];
			addr = a + {{10{iw[5]}}, iw[5:0]};
			res = '0;
			writes = 1'b1;
			next_pc = pending ? target : pc + 1;
			pending = 1'b0;
			case (op)
				`OP_ADD: res = a + b;
				`OP_SUB: res = a - b;
				`OP_AND: res = a & b;
				`OP_OR: res = a | b;
				`OP_XOR: res = a ^ b;
				`OP_SLT: res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				`OP_LI: res = {8'h00, iw[7:0]};
				`OP_ADDI: res = addr;
				`OP_LW: res = model_mem[addr[`DMEM_ADDR_WIDTH-1:0]];
				`OP_SW: begin
					model_mem[addr[`DMEM_ADDR_WIDTH-1:0]] = regs[rd];
					writes = 1'b0;
				end
				`OP_BEQZ, `OP_BNEZ: begin
					writes = 1'b0;
					if ((regs[rd] == 16'd0) == (op == `OP_BEQZ)) begin
						pending = 1'b1;
						target = pc + 1 + int'($signed(iw[8:0]));
					end
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				regs[rd] = res;
				w.en = 1'b1;
				w.addr = rd;
				w.value = res;
				expected.push_back(w);
			end
			pc = next_pc;
		end
	endtask

	// pc at zero and no write retiring
	task automatic check_reset_state(string name);
		if (inst_addr !== 16'd0) begin
			$display("Fail %s reset: inst_addr expected %h, actual %h", name, 16'd0, inst_addr);
			test_errors++;
		end
		if (retire.en !== 1'b0) begin
			$display("Fail %s reset: retire.en expected 0, actual %b", name, retire.en);
			test_errors++;
		end
	endtask

	task automatic reset_dut(string name);
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			if (i > 0) begin
				check_reset_state(name);
			end
			@(posedge clk);
		end
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_reset_state(name);
	endtask

	task automatic wait_retire(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (retire.en === 1'b1) begin
				seen = 1'b1;
			end
		end
	endtask

	task automatic report_test(string name);
		if (test_errors == 0) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, test_errors);
			tests_failed++;
		end
	endtask

	task automatic run_program(string name);
		logic seen;
		logic timed_out;
		int idx;
		int quiet;
		test_errors = 0;
		run_model();
		reset_dut(name);
		idx = 0;
		timed_out = 1'b0;
		while (!timed_out && idx < expected.size()) begin
			wait_retire(seen);
			if (!seen) begin
				$display("%s: no register write within %0d cycles, got %0d of %0d",
					name, WAIT_CYCLES, idx, expected.size());
				test_errors++;
				timed_out = 1'b1;
			end else begin
				if (retire.addr !== expected[idx].addr || retire.value !== expected[idx].value) begin
					$display("Fail %s write %0d: expected r%0d = %h, actual r%0d = %h", name, idx,
						expected[idx].addr, expected[idx].value, retire.addr, retire.value);
					test_errors++;
				end
				idx++;
			end
		end
		// nothing may retire once the model's list is used up
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clk);
			if (retire.en === 1'b1) begin
				$display("%s: extra register write to r%0d after the last expected one",
					name, retire.addr);
				test_errors++;
			end
			quiet++;
		end
		report_test(name);
	endtask

	initial begin
		void'($urandom(32'h21dc807d));
		rst_n = 1'b0;
		tests_passed = 0;
		tests_failed = 0;
		test_errors = 0;
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			model_mem[i] = '0;
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i] = NOP_WORD;
		end

		// all nops, so retire must stay quiet
		reset_dut("reset");
		repeat (20) begin
			@(negedge clk);
			if (retire.en !== 1'b0) begin
				$display("Fail reset: retire.en expected 0, actual %b", retire.en);
				test_errors++;
			end
		end
		report_test("reset");

		for (int i = 0; i < 4; i++) begin
			prog[i] = {`OP_LI, 3'(i), 1'b0, 8'($urandom)};
		end
		fill_random(4, 1'b0, 1'b0, 4);
		run_program("alu_bypass");

		// unwritten word first, then store and load back
		prog[0] = {`OP_LW, 3'd3, 3'd0, 6'd31};
		prog[1] = {`OP_LI, 3'd1, 1'b0, 8'ha5};
		prog[2] = {`OP_SW, 3'd1, 3'd0, 6'd4};
		prog[3] = {`OP_LW, 3'd2, 3'd0, 6'd4};
		prog[4] = {`OP_ADD, 3'd4, 3'd2, 3'd2, 3'b000};
		prog[5] = {`OP_LI, 3'd5, 1'b0, 8'h3c};
		prog[6] = {`OP_SW, 3'd5, 3'd2, 6'd0};
		prog[7] = {`OP_LW, 3'd6, 3'd2, 6'd0};
		fill_random(8, 1'b1, 1'b0, 8);
		run_program("load_store");

		// r0 stays zero so the beqz is taken and the bnez falls through
		prog[0] = {`OP_LI, 3'd0, 1'b0, 8'h00};
		prog[1] = {`OP_LI, 3'd1, 1'b0, 8'($urandom)};
		prog[2] = {`OP_LI, 3'd2, 1'b0, 8'($urandom)};
		prog[3] = {`OP_LI, 3'd3, 1'b0, 8'($urandom)};
		prog[4] = {`OP_BEQZ, 3'd0, 9'd3};
		prog[5] = {`OP_LI, 3'd1, 1'b0, 8'h11};
		// skipped by the taken beqz
		prog[6] = {`OP_LI, 3'd3, 1'b0, 8'h22};
		prog[7] = {`OP_LI, 3'd2, 1'b0, 8'h33};
		prog[8] = {`OP_BNEZ, 3'd0, 9'd2};
		prog[9] = {`OP_LI, 3'd3, 1'b0, 8'h44};
		fill_random(10, 1'b0, 1'b1, 4);
		run_program("branch");

		fill_random(0, 1'b1, 1'b1, 8);
		run_program("mixed");

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* cpu_top.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/decoder.sv
verilog/alu.sv
verilog/mem_ctrl.sv
verilog/data_ram.sv
verilog/cpu_top.sv
verif/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f cpu_top.f \
	--Mdir obj_dir -o cpu_sim
out=$(./obj_dir/cpu_sim)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
